//--- Bender.yml
package:
  name: lm80c_glue

sources:
  - lm80c_glue_pkg.sv
  - mem_eraser.sv
  - boot_sig_check.sv
  - mem_bus_arbiter.sv
  - io_decoder.sv
  - lm80c_glue.sv
  - target: test
    files:
      - tb_glue_checks.sv
      - tb_lm80c_glue.sv

//--- boot_sig_check.sv
module boot_sig_check (
	input  logic                     CLOCK,
	input  logic                     rst_i,
	input  logic                     start_i,      // CPU running, loader idle
	input  lm80c_glue_pkg::byte_t    mem_rdata_i,
	output logic                     busy_o,
	output lm80c_glue_pkg::mem_req_t req_o,
	output logic                     sig_ok_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_DONE
	} state_t;

	state_t                state_q;
	logic [2:0]            idx_q;     // Address being read, SIG_LEN when reads are over
	logic                  pend_q;    // Last cycle issued a read
	logic                  match_q;   // Bytes compared so far all matched
	logic [1:0]            cmp_idx;   // Address of the byte arriving now
	lm80c_glue_pkg::byte_t exp_byte;
	logic                  byte_ok;

	assign cmp_idx  = 2'(idx_q - 3'd1);
	assign exp_byte = lm80c_glue_pkg::BOOT_SIG[cmp_idx*8 +: 8];
	assign byte_ok  = (mem_rdata_i == exp_byte);

	assign busy_o = (state_q == S_READ);

	// Read only, address is the index
	always_comb begin
		req_o      = '0;
		req_o.addr = lm80c_glue_pkg::addr_t'(idx_q);
		req_o.oe   = busy_o && (idx_q < 3'(lm80c_glue_pkg::SIG_LEN));
	end

	always_ff @(posedge CLOCK) begin
		if (rst_i) begin
			state_q  <= S_IDLE;
			idx_q    <= '0;
			pend_q   <= 1'b0;
			match_q  <= 1'b1;
			sig_ok_o <= 1'b0;
		end else if (!start_i) begin
			state_q <= S_IDLE;     // Re-arm, LED keeps last result
			pend_q  <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: begin
					state_q  <= S_READ;
					idx_q    <= '0;
					pend_q   <= 1'b0;
					match_q  <= 1'b1;
					sig_ok_o <= 1'b0;  // New run, old result cleared
				end
				S_READ: begin
					pend_q <= (idx_q < 3'(lm80c_glue_pkg::SIG_LEN));
					if (pend_q)
						match_q <= match_q & byte_ok;
					if (idx_q == 3'(lm80c_glue_pkg::SIG_LEN)) begin
						state_q  <= S_DONE;                // Fifth busy cycle
						sig_ok_o <= match_q & byte_ok;     // Last byte compared here
					end else begin
						idx_q <= idx_q + 3'd1;
					end
				end
				S_DONE: state_q <= S_DONE;   // Wait for start_i to drop
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// ROM is never written by the checker
	a_no_write: assert property (
		@(posedge CLOCK) disable iff (rst_i)
		!req_o.we
	) else $error("boot checker issued a write");

endmodule

//--- io_decoder.sv
module io_decoder (
	input  lm80c_glue_pkg::cpu_bus_t  cpu_i,
	input  lm80c_glue_pkg::byte_t     ctc_rdata_i,
	input  lm80c_glue_pkg::byte_t     vdp_rdata_i,
	input  lm80c_glue_pkg::byte_t     psg_rdata_i,
	input  lm80c_glue_pkg::byte_t     mem_rdata_i,
	output lm80c_glue_pkg::io_sel_t   io_sel_o,
	output lm80c_glue_pkg::dev_ctrl_t dev_ctrl_o,
	output lm80c_glue_pkg::byte_t     cpu_rdata_o
);

	logic       io_cyc;   // I/O cycle, not memory
	logic [3:0] page;     // A7..A4

	assign io_cyc = cpu_i.iorq & ~cpu_i.mreq;
	assign page   = cpu_i.addr[7:4];

	// Device selects, one page each
	always_comb begin
		io_sel_o.pio = io_cyc && (page == lm80c_glue_pkg::IO_PIO);
		io_sel_o.ctc = io_cyc && (page == lm80c_glue_pkg::IO_CTC);
		io_sel_o.sio = io_cyc && (page == lm80c_glue_pkg::IO_SIO);
		io_sel_o.vdp = io_cyc && (page == lm80c_glue_pkg::IO_VDP);
		io_sel_o.psg = io_cyc && (page == lm80c_glue_pkg::IO_PSG);
	end

	// VDP port strobes
	always_comb begin
		dev_ctrl_o.vdp_rd   = io_sel_o.vdp & cpu_i.rd;
		dev_ctrl_o.vdp_wr   = io_sel_o.vdp & cpu_i.wr;
		dev_ctrl_o.vdp_mode = cpu_i.addr[1];          // Data or register port
		// PSG bus control, BDIR on writes, BC from A0
		dev_ctrl_o.psg_bdir = io_sel_o.psg & cpu_i.wr;
		dev_ctrl_o.psg_bc   = io_sel_o.psg & cpu_i.addr[0];
	end

	// Read data back to the Z80
	always_comb begin
		if (io_sel_o.pio || io_sel_o.sio)
			cpu_rdata_o = '0;             // No PIO or SIO model here
		else if (io_sel_o.ctc)
			cpu_rdata_o = ctc_rdata_i;
		else if (io_sel_o.vdp)
			cpu_rdata_o = vdp_rdata_i;
		else if (io_sel_o.psg)
			cpu_rdata_o = psg_rdata_i;
		else
			cpu_rdata_o = mem_rdata_i;    // Memory, or an unmapped page
	end

	// At most one device on the bus
	a_sel_onehot: assert final ($onehot0(io_sel_o))
		else $error("more than one I/O select: %b", io_sel_o);

endmodule

//--- lm80c_glue.f
lm80c_glue_pkg.sv
mem_eraser.sv
boot_sig_check.sv
mem_bus_arbiter.sv
io_decoder.sv
lm80c_glue.sv
tb_glue_checks.sv
tb_lm80c_glue.sv

//--- lm80c_glue.sv
module lm80c_glue #(
	parameter int ERASE_WORDS = 32768           // Bytes cleared per erase sweep
) (
	input  logic                       CLOCK,
	input  logic                       rst_i,        // PLL not locked yet

	// Z80 side
	input  lm80c_glue_pkg::cpu_bus_t   cpu_i,
	input  lm80c_glue_pkg::byte_t      cpu_wdata_i,

	// ROM loader port
	input  logic                       load_busy_i,
	input  logic                       load_we_i,
	input  lm80c_glue_pkg::addr_t      load_addr_i,
	input  lm80c_glue_pkg::byte_t      load_data_i,
	input  logic                       boot_done_i,  // High after first load

	input  logic                       erase_i,      // Rising edge starts sweep
	input  logic                       reset_key_i,

	// Read bytes from memory and devices
	input  lm80c_glue_pkg::byte_t      mem_rdata_i,
	input  lm80c_glue_pkg::byte_t      ctc_rdata_i,
	input  lm80c_glue_pkg::byte_t      vdp_rdata_i,
	input  lm80c_glue_pkg::byte_t      psg_rdata_i,

	output lm80c_glue_pkg::mem_req_t   mem_req_o,
	output lm80c_glue_pkg::byte_t      cpu_rdata_o,
	output logic                       cpu_wait_o,
	output logic                       cpu_reset_o,
	output lm80c_glue_pkg::io_sel_t    io_sel_o,
	output lm80c_glue_pkg::dev_ctrl_t  dev_ctrl_o,
	output logic                       sig_ok_o      // LED
);

	logic                     erase_busy;
	lm80c_glue_pkg::mem_req_t erase_req;
	logic                     chk_busy;
	logic                     chk_start;   // CPU out of reset, loader idle
	lm80c_glue_pkg::mem_req_t chk_req;

	mem_eraser #(
		.ERASE_WORDS (ERASE_WORDS)
	) u_eraser (
		.CLOCK   (CLOCK),
		.rst_i   (rst_i),
		.erase_i (erase_i),
		.busy_o  (erase_busy),
		.req_o   (erase_req)
	);

	boot_sig_check u_checker (
		.CLOCK       (CLOCK),
		.rst_i       (rst_i),
		.start_i     (chk_start),
		.mem_rdata_i (mem_rdata_i),
		.busy_o      (chk_busy),
		.req_o       (chk_req),
		.sig_ok_o    (sig_ok_o)
	);

	mem_bus_arbiter u_arbiter (
		.CLOCK        (CLOCK),
		.rst_i        (rst_i),
		.cpu_i        (cpu_i),
		.cpu_wdata_i  (cpu_wdata_i),
		.load_busy_i  (load_busy_i),
		.load_we_i    (load_we_i),
		.load_addr_i  (load_addr_i),
		.load_data_i  (load_data_i),
		.boot_done_i  (boot_done_i),
		.reset_key_i  (reset_key_i),
		.erase_busy_i (erase_busy),
		.erase_req_i  (erase_req),
		.chk_busy_i   (chk_busy),
		.chk_req_i    (chk_req),
		.mem_req_o    (mem_req_o),
		.chk_start_o  (chk_start),
		.cpu_wait_o   (cpu_wait_o),
		.cpu_reset_o  (cpu_reset_o)
	);

	io_decoder u_io (
		.cpu_i       (cpu_i),
		.ctc_rdata_i (ctc_rdata_i),
		.vdp_rdata_i (vdp_rdata_i),
		.psg_rdata_i (psg_rdata_i),
		.mem_rdata_i (mem_rdata_i),
		.io_sel_o    (io_sel_o),
		.dev_ctrl_o  (dev_ctrl_o),
		.cpu_rdata_o (cpu_rdata_o)
	);

endmodule

//--- lm80c_glue_pkg.sv
package lm80c_glue_pkg;

	// Bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] byte_t;

	// Memory map
	localparam int    RAM_BIT    = 15;        // Set means RAM, clear means ROM
	localparam addr_t ERASE_BASE = 16'h8000;  // Start of RAM
	localparam byte_t FILL_BYTE  = 8'h00;

	// First four ROM bytes, address 0 in the low byte
	localparam int SIG_LEN = 4;
	localparam logic [SIG_LEN*DATA_W-1:0] BOOT_SIG = {8'h02, 8'h5A, 8'hC3, 8'hF3};

	// I/O page codes in A7..A4
	localparam logic [3:0] IO_PIO = 4'd0;
	localparam logic [3:0] IO_CTC = 4'd1;
	localparam logic [3:0] IO_SIO = 4'd2;
	localparam logic [3:0] IO_VDP = 4'd3;
	localparam logic [3:0] IO_PSG = 4'd4;

	// Z80 bus as seen by the glue, strobes active high
	typedef struct packed {
		addr_t addr;
		logic  mreq;
		logic  iorq;
		logic  rd;
		logic  wr;
	} cpu_bus_t;

	// One request to the external memory
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  we;    // Write level
		logic  oe;    // Read level, data one cycle later
	} mem_req_t;

	typedef struct packed {
		logic pio;
		logic ctc;
		logic sio;
		logic vdp;
		logic psg;
	} io_sel_t;

	typedef struct packed {
		logic vdp_rd;
		logic vdp_wr;
		logic vdp_mode;  // A1 selects VDP data or control port
		logic psg_bdir;
		logic psg_bc;
	} dev_ctrl_t;

endpackage

//--- mem_bus_arbiter.sv
module mem_bus_arbiter (
	input  logic                     CLOCK,
	input  logic                     rst_i,
	input  lm80c_glue_pkg::cpu_bus_t cpu_i,
	input  lm80c_glue_pkg::byte_t    cpu_wdata_i,
	input  logic                     load_busy_i,
	input  logic                     load_we_i,
	input  lm80c_glue_pkg::addr_t    load_addr_i,
	input  lm80c_glue_pkg::byte_t    load_data_i,
	input  logic                     boot_done_i,
	input  logic                     reset_key_i,
	input  logic                     erase_busy_i,
	input  lm80c_glue_pkg::mem_req_t erase_req_i,
	input  logic                     chk_busy_i,
	input  lm80c_glue_pkg::mem_req_t chk_req_i,
	output lm80c_glue_pkg::mem_req_t mem_req_o,
	output logic                     chk_start_o,
	output logic                     cpu_wait_o,
	output logic                     cpu_reset_o
);

	lm80c_glue_pkg::mem_req_t load_req;
	lm80c_glue_pkg::mem_req_t cpu_req;

	// Reset while booting or while the key is held
	assign cpu_reset_o = ~boot_done_i | reset_key_i;

	// Freeze CPU whenever another master owns the bus
	assign cpu_wait_o = ~boot_done_i | load_busy_i | erase_busy_i | chk_busy_i;

	// Signature check may run once the CPU is released
	assign chk_start_o = ~cpu_reset_o & ~load_busy_i;

	// Loader only writes
	always_comb begin
		load_req       = '0;
		load_req.addr  = load_addr_i;
		load_req.wdata = load_data_i;
		load_req.we    = load_we_i;
	end

	always_comb begin
		cpu_req       = '0;
		cpu_req.addr  = cpu_i.addr;
		cpu_req.wdata = cpu_wdata_i;
		cpu_req.we    = cpu_i.mreq & cpu_i.wr
		                & cpu_i.addr[lm80c_glue_pkg::RAM_BIT];   // ROM is write protected
		cpu_req.oe    = cpu_i.mreq & cpu_i.rd;
	end

	// Fixed priority, losers simply wait
	always_comb begin
		if (load_busy_i)
			mem_req_o = load_req;
		else if (erase_busy_i)
			mem_req_o = erase_req_i;
		else if (chk_busy_i)
			mem_req_o = chk_req_i;
		else
			mem_req_o = cpu_req;
	end

	// Eraser and checker never share a cycle
	a_one_bg_master: assert property (
		@(posedge CLOCK) disable iff (rst_i)
		!(erase_busy_i && chk_busy_i)
	) else $error("eraser and boot checker busy together");

endmodule

//--- mem_eraser.sv
module mem_eraser #(
	parameter int ERASE_WORDS = 32768
) (
	input  logic                     CLOCK,
	input  logic                     rst_i,
	input  logic                     erase_i,
	output logic                     busy_o,
	output lm80c_glue_pkg::mem_req_t req_o
);

	localparam int CNT_W     = (ERASE_WORDS > 1) ? $clog2(ERASE_WORDS) : 1;
	localparam int LAST_ADDR = int'(lm80c_glue_pkg::ERASE_BASE) + ERASE_WORDS - 1;

	logic             erase_q;   // Previous erase_i for edge detect
	logic [CNT_W-1:0] cnt_q;     // Offset of the byte written this cycle
	logic             start;

	// Edges during a sweep are dropped
	assign start = erase_i & ~erase_q & ~busy_o;

	always_ff @(posedge CLOCK) begin
		if (rst_i) begin
			erase_q <= 1'b0;
			busy_o  <= 1'b0;
			cnt_q   <= '0;
		end else begin
			erase_q <= erase_i;
			if (start) begin
				busy_o <= 1'b1;
				cnt_q  <= '0;
			end else if (busy_o) begin
				if (cnt_q == CNT_W'(ERASE_WORDS - 1))
					busy_o <= 1'b0;             // Last write this cycle
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// One fill write per busy cycle
	always_comb begin
		req_o       = '0;
		req_o.addr  = lm80c_glue_pkg::ERASE_BASE + lm80c_glue_pkg::addr_t'(cnt_q);
		req_o.wdata = lm80c_glue_pkg::FILL_BYTE;
		req_o.we    = busy_o;
	end

	// Sweep stays inside the erased region
	a_addr_range: assert property (
		@(posedge CLOCK) disable iff (rst_i)
		busy_o |-> (int'(req_o.addr) <= LAST_ADDR)
	) else $error("eraser address 0x%h past end of region", req_o.addr);

endmodule

//--- tb_glue_checks.sv
package tb_glue_checks;

	// Request the arbiter passes for a CPU cycle, ROM below the RAM bit
	function automatic lm80c_glue_pkg::mem_req_t cpu_req_model(
		input lm80c_glue_pkg::cpu_bus_t cpu,
		input lm80c_glue_pkg::byte_t    wdata
	);
		lm80c_glue_pkg::mem_req_t req;
		req       = '0;
		req.addr  = cpu.addr;
		req.wdata = wdata;
		req.oe    = cpu.mreq && cpu.rd;                  // Reads from anywhere
		if (cpu.mreq && cpu.wr && cpu.addr[lm80c_glue_pkg::RAM_BIT])
			req.we = 1'b1;
		return req;
	endfunction

	// One-hot page select for I/O cycles only
	function automatic lm80c_glue_pkg::io_sel_t sel_model(input lm80c_glue_pkg::cpu_bus_t cpu);
		lm80c_glue_pkg::io_sel_t sel;
		sel = '0;
		if (cpu.iorq && !cpu.mreq) begin
			case (cpu.addr[7:4])
				lm80c_glue_pkg::IO_PIO: sel.pio = 1'b1;
				lm80c_glue_pkg::IO_CTC: sel.ctc = 1'b1;
				lm80c_glue_pkg::IO_SIO: sel.sio = 1'b1;
				lm80c_glue_pkg::IO_VDP: sel.vdp = 1'b1;
				lm80c_glue_pkg::IO_PSG: sel.psg = 1'b1;
				default: ;                               // Unmapped page
			endcase
		end
		return sel;
	endfunction

	function automatic lm80c_glue_pkg::dev_ctrl_t ctrl_model(input lm80c_glue_pkg::cpu_bus_t cpu);
		lm80c_glue_pkg::io_sel_t   sel;
		lm80c_glue_pkg::dev_ctrl_t ctrl;
		sel           = sel_model(cpu);
		ctrl.vdp_rd   = sel.vdp && cpu.rd;
		ctrl.vdp_wr   = sel.vdp && cpu.wr;
		ctrl.vdp_mode = cpu.addr[1];
		ctrl.psg_bdir = sel.psg && cpu.wr;
		ctrl.psg_bc   = sel.psg && cpu.addr[0];
		return ctrl;
	endfunction

	// Device byte if one is selected, else memory
	function automatic lm80c_glue_pkg::byte_t io_rdata_model(
		input lm80c_glue_pkg::cpu_bus_t cpu,
		input lm80c_glue_pkg::byte_t    ctc,
		input lm80c_glue_pkg::byte_t    vdp,
		input lm80c_glue_pkg::byte_t    psg,
		input lm80c_glue_pkg::byte_t    mem
	);
		lm80c_glue_pkg::io_sel_t sel;
		sel = sel_model(cpu);
		if (sel.ctc)
			return ctc;
		if (sel.vdp)
			return vdp;
		if (sel.psg)
			return psg;
		if (sel.pio || sel.sio)
			return 8'h00;
		return mem;
	endfunction

	task automatic check_req(input string name, input lm80c_glue_pkg::mem_req_t exp,
			input lm80c_glue_pkg::mem_req_t act, output bit ok);
		ok = (act === exp);
		if (!ok)
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
	endtask

	task automatic check_sel(input string name, input lm80c_glue_pkg::io_sel_t exp,
			input lm80c_glue_pkg::io_sel_t act, output bit ok);
		ok = (act === exp);
		if (!ok)
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
	endtask

	task automatic check_ctrl(input string name, input lm80c_glue_pkg::dev_ctrl_t exp,
			input lm80c_glue_pkg::dev_ctrl_t act, output bit ok);
		ok = (act === exp);
		if (!ok)
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
	endtask

	task automatic check_byte(input string name, input lm80c_glue_pkg::byte_t exp,
			input lm80c_glue_pkg::byte_t act, output bit ok);
		ok = (act === exp);
		if (!ok)
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act, output bit ok);
		ok = (act === exp);
		if (!ok)
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
	endtask

	task automatic check_count(input string name, input int exp, input int act, output bit ok);
		ok = (act == exp);
		if (!ok)
			$display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
	endtask

endpackage

//--- tb_lm80c_glue.sv
module tb_lm80c_glue;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ERASE_WORDS = 64;
	localparam int TIMEOUT     = 2000;   // Cycles per wait

	logic                      CLOCK;
	logic                      rst_i;
	lm80c_glue_pkg::cpu_bus_t  cpu_i;
	lm80c_glue_pkg::byte_t     cpu_wdata_i;
	logic                      load_busy_i;
	logic                      load_we_i;
	lm80c_glue_pkg::addr_t     load_addr_i;
	lm80c_glue_pkg::byte_t     load_data_i;
	logic                      boot_done_i;
	logic                      erase_i;
	logic                      reset_key_i;
	lm80c_glue_pkg::byte_t     mem_rdata_i;
	lm80c_glue_pkg::byte_t     ctc_rdata_i;
	lm80c_glue_pkg::byte_t     vdp_rdata_i;
	lm80c_glue_pkg::byte_t     psg_rdata_i;
	lm80c_glue_pkg::mem_req_t  mem_req_o;
	lm80c_glue_pkg::byte_t     cpu_rdata_o;
	logic                      cpu_wait_o;
	logic                      cpu_reset_o;
	lm80c_glue_pkg::io_sel_t   io_sel_o;
	lm80c_glue_pkg::dev_ctrl_t dev_ctrl_o;
	logic                      sig_ok_o;

	lm80c_glue_pkg::byte_t     mem [0:65535];   // 64K memory model
	lm80c_glue_pkg::mem_req_t  req_seen;        // Request sampled mid-cycle
	lm80c_glue_pkg::byte_t     rd_next;
	int                        fill_writes;     // Fill bytes landing in the erase region

	lm80c_glue #(.ERASE_WORDS(ERASE_WORDS)) u_lm80c_glue (.*);

	initial begin
		CLOCK = 1'b0;
		forever #20 CLOCK = ~CLOCK;
	end

	initial begin
		for (int a = 0; a < 65536; a++)
			mem[a] = lm80c_glue_pkg::byte_t'(a[15:8] ^ a[7:0] ^ 8'hA5);  // Whole-address pattern
		rd_next     = '0;
		mem_rdata_i = '0;
	end

	always @(negedge CLOCK)
		req_seen = mem_req_o;

	// Write lands at the edge, read byte shows up just after it
	always @(posedge CLOCK) begin
		if (req_seen.we === 1'b1) begin
			mem[req_seen.addr] = req_seen.wdata;
			if (req_seen.addr >= lm80c_glue_pkg::ERASE_BASE
			    && req_seen.addr < lm80c_glue_pkg::ERASE_BASE + ERASE_WORDS
			    && req_seen.wdata == lm80c_glue_pkg::FILL_BYTE)
				fill_writes++;
		end
		if (req_seen.oe === 1'b1)
			rd_next = mem[req_seen.addr];
		#2 mem_rdata_i = rd_next;
	end

	task automatic next_cycle();
		@(posedge CLOCK);
		#2;                                  // Drive point
	endtask

	task automatic settle();
		#10;                                 // Outputs stable, well before the negedge
	endtask

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic halt_unless(input bit ok);
		if (!ok)
			stop_run();
	endtask

	// Poll sig_ok_o or cpu_wait_o once per cycle
	task automatic wait_until(input bit use_sig_ok, input logic level, input string what);
		int n;
		n = 0;
		while ((use_sig_ok ? sig_ok_o : cpu_wait_o) !== level) begin
			if (n == TIMEOUT) begin
				$display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
				stop_run();
			end
			next_cycle();
			settle();
			n++;
		end
	endtask

	// Random Z80 cycle, exactly one of rd and wr
	task automatic drive_cpu(input bit io);
		logic rd;
		rd          = 1'($urandom_range(0, 1));
		cpu_i.addr  = io ? {8'($urandom), 4'($urandom_range(0, 7)), 4'($urandom)}
		                 : {1'($urandom), 9'd0, 6'($urandom)};   // Small window, RAM and ROM
		cpu_i.mreq  = io ? ($urandom_range(0, 7) == 0) : 1'b1;
		cpu_i.iorq  = io;
		cpu_i.rd    = rd;
		cpu_i.wr    = ~rd;
		cpu_wdata_i = 8'($urandom);
	endtask

	initial begin
		lm80c_glue_pkg::mem_req_t exp_req;
		lm80c_glue_pkg::byte_t    exp_byte;
		logic                     read_pending;
		int                       sweep_len;
		bit                       ok;

		void'($urandom(48));
		rst_i       = 1'b1;
		cpu_i       = '0;
		cpu_wdata_i = '0;
		load_busy_i = 1'b0;
		load_we_i   = 1'b0;
		load_addr_i = '0;
		load_data_i = '0;
		boot_done_i = 1'b0;
		erase_i     = 1'b0;
		reset_key_i = 1'b0;
		ctc_rdata_i = '0;
		vdp_rdata_i = '0;
		psg_rdata_i = '0;
		fill_writes = 0;
		repeat (4) next_cycle();
		rst_i = 1'b0;
		settle();
		tb_glue_checks::check_bit("sig_ok after reset", 1'b0, sig_ok_o, ok);
		halt_unless(ok);

		// Loader owns the bus over CPU noise, signature last
		for (int i = 0; i < 54; i++) begin
			next_cycle();
			load_busy_i = 1'b1;
			load_we_i   = 1'b1;
			load_addr_i = (i < 50) ? 16'($urandom) : 16'(i - 50);
			load_data_i = (i < 50) ? 8'($urandom) : lm80c_glue_pkg::BOOT_SIG[(i-50)*8 +: 8];
			drive_cpu(1'b0);
			settle();
			exp_req       = '0;
			exp_req.addr  = load_addr_i;
			exp_req.wdata = load_data_i;
			exp_req.we    = 1'b1;
			tb_glue_checks::check_req("loader priority", exp_req, mem_req_o, ok);
			halt_unless(ok);
			tb_glue_checks::check_bit("cpu wait while loading", 1'b1, cpu_wait_o, ok);
			halt_unless(ok);
			tb_glue_checks::check_bit("cpu reset before boot", 1'b1, cpu_reset_o, ok);
			halt_unless(ok);
		end

		next_cycle();
		load_busy_i = 1'b0;
		load_we_i   = 1'b0;
		boot_done_i = 1'b1;
		cpu_i       = '0;                    // CPU idle while the check runs
		settle();
		wait_until(1'b1, 1'b1, "sig_ok_o after good boot");
		tb_glue_checks::check_bit("cpu wait after check", 1'b0, cpu_wait_o, ok);
		halt_unless(ok);
		tb_glue_checks::check_bit("cpu reset after boot", 1'b0, cpu_reset_o, ok);
		halt_unless(ok);

		// Bad byte at address 2, key press reruns the check
		next_cycle();
		load_busy_i = 1'b1;
		load_we_i   = 1'b1;
		load_addr_i = 16'd2;
		load_data_i = 8'hFF;
		next_cycle();
		load_busy_i = 1'b0;
		load_we_i   = 1'b0;
		reset_key_i = 1'b1;
		settle();
		tb_glue_checks::check_bit("cpu reset on key", 1'b1, cpu_reset_o, ok);
		halt_unless(ok);
		repeat (3) next_cycle();
		reset_key_i = 1'b0;
		settle();
		wait_until(1'b0, 1'b1, "second check to start");
		wait_until(1'b0, 1'b0, "second check to end");
		tb_glue_checks::check_bit("bad signature", 1'b0, sig_ok_o, ok);
		halt_unless(ok);

		// CPU memory path with ROM write protect
		read_pending = 1'b0;
		exp_byte     = '0;
		for (int i = 0; i < 200; i++) begin
			next_cycle();
			drive_cpu(1'b0);
			settle();
			if (read_pending) begin
				tb_glue_checks::check_byte("cpu read data", exp_byte, cpu_rdata_o, ok);
				halt_unless(ok);
			end
			exp_req = tb_glue_checks::cpu_req_model(cpu_i, cpu_wdata_i);
			tb_glue_checks::check_req("cpu memory request", exp_req, mem_req_o, ok);
			halt_unless(ok);
			tb_glue_checks::check_bit("cpu wait when idle", 1'b0, cpu_wait_o, ok);
			halt_unless(ok);
			read_pending = exp_req.oe;
			exp_byte     = mem[cpu_i.addr];
		end

		// Erase sweep with CPU reads pending and a stray edge mid-sweep
		next_cycle();
		fill_writes = 0;                     // Last CPU write has landed by now
		cpu_i   = '0;
		erase_i = 1'b1;
		settle();
		wait_until(1'b0, 1'b1, "erase sweep to start");
		sweep_len = 0;
		while (cpu_wait_o === 1'b1) begin
			if (sweep_len == TIMEOUT) begin
				$display("Timeout, erase sweep never ended");
				stop_run();
			end
			exp_req       = '0;
			exp_req.addr  = lm80c_glue_pkg::ERASE_BASE + lm80c_glue_pkg::addr_t'(sweep_len);
			exp_req.wdata = lm80c_glue_pkg::FILL_BYTE;
			exp_req.we    = 1'b1;
			tb_glue_checks::check_req("erase write", exp_req, mem_req_o, ok);
			halt_unless(ok);
			sweep_len++;
			next_cycle();
			erase_i = (sweep_len < 12) && ((sweep_len % 8) < 4);  // Rises again at 8
			cpu_i   = {16'($urandom), 1'b1, 1'b0, 1'b1, 1'b0};    // Read only
			settle();
		end
		tb_glue_checks::check_count("erase sweep length", ERASE_WORDS, sweep_len, ok);
		halt_unless(ok);
		tb_glue_checks::check_count("fill writes seen", ERASE_WORDS, fill_writes, ok);
		halt_unless(ok);
		for (int a = 0; a < ERASE_WORDS; a++) begin
			tb_glue_checks::check_byte("erased byte", lm80c_glue_pkg::FILL_BYTE,
				mem[lm80c_glue_pkg::ERASE_BASE + a], ok);
			halt_unless(ok);
		end

		// I/O decode, pages 5 to 7 unmapped
		for (int i = 0; i < 200; i++) begin
			next_cycle();
			drive_cpu(1'b1);
			ctc_rdata_i = 8'($urandom);
			vdp_rdata_i = 8'($urandom);
			psg_rdata_i = 8'($urandom);
			settle();
			tb_glue_checks::check_sel("io select", tb_glue_checks::sel_model(cpu_i), io_sel_o, ok);
			halt_unless(ok);
			tb_glue_checks::check_ctrl("device control", tb_glue_checks::ctrl_model(cpu_i),
				dev_ctrl_o, ok);
			halt_unless(ok);
			exp_byte = tb_glue_checks::io_rdata_model(cpu_i, ctc_rdata_i, vdp_rdata_i,
				psg_rdata_i, mem_rdata_i);
			tb_glue_checks::check_byte("io read data", exp_byte, cpu_rdata_o, ok);
			halt_unless(ok);
		end

		$display("All tests passed!");
		$finish;
	end

endmodule
